/* hw/capture_pkg.sv */
package capture_pkg;

  // Stream and memory sizes
  localparam int sample_width   = 32;
  localparam int data_width     = 64;                 // Two samples per beat
  localparam int ram_addr_width = 8;                  // 256 beat words
  localparam int id_width       = 4;

  // Burst and ring geometry
  localparam int burst_len       = 16;                // Beats per burst
  localparam int beat_cnt_width  = $clog2(burst_len);
  localparam int ring_words      = 64;                // Four bursts per ring
  localparam int ring_addr_width = $clog2(ring_words);

  // Peer writers sharing the memory
  localparam int num_writers      = 2;
  localparam int writer_sel_width = $clog2(num_writers);

  // Write address request
  typedef struct packed {
    logic [id_width-1:0]       id;
    logic [ram_addr_width-1:0] addr;                  // Beat address of the first beat
  } aw_req_t;

  // One write data beat
  typedef struct packed {
    logic [data_width-1:0] data;
    logic                  last;                      // Final beat of the burst
  } w_beat_t;

endpackage

/* hw/axis_ram_writer.sv */
`timescale 1ns/1ps

module axis_ram_writer #(
  parameter logic [capture_pkg::ram_addr_width-1:0] region_base = '0
) (
  input  logic                                 aclk,
  input  logic                                 aresetn,
  input  logic [capture_pkg::sample_width-1:0] tdata,
  input  logic                                 tvalid,
  output logic                                 tready,
  output capture_pkg::aw_req_t                 aw,
  output logic                                 aw_valid,
  input  logic                                 aw_ready,
  output capture_pkg::w_beat_t                 w,
  output logic                                 w_valid,
  input  logic                                 w_ready
);

  import capture_pkg::*;

  logic [sample_width-1:0]    low_q;                  // First sample of the open pair
  logic [data_width-1:0]      beat_q;                 // Beat offered on w
  logic                       half_q, half_d;         // Low half already captured
  logic                       w_valid_q, w_valid_d;
  logic                       aw_valid_q, aw_valid_d;
  logic [ring_addr_width-1:0] offset_q, offset_d;     // Next beat inside the ring
  logic [id_width-1:0]        id_q, id_d;
  logic                       take;
  logic                       pair_done;
  logic                       beat_done;
  logic                       last_beat;

  assign take      = tvalid & tready;
  assign pair_done = take & half_q;
  assign beat_done = w_valid_q & w_ready;
  assign last_beat = &offset_q[beat_cnt_width-1:0];  // Ring is burst aligned

  // Stall the stream only while a full beat is stuck on w
  assign tready = ~w_valid_q | w_ready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      half_q     <= 1'b0;
      w_valid_q  <= 1'b0;
      aw_valid_q <= 1'b0;
      offset_q   <= '0;
      id_q       <= '0;
    end
    else
    begin
      half_q     <= half_d;
      w_valid_q  <= w_valid_d;
      aw_valid_q <= aw_valid_d;
      offset_q   <= offset_d;
      id_q       <= id_d;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (take && !half_q)
      low_q <= tdata;
    if (pair_done)
      beat_q <= {tdata, low_q};                       // Earlier sample in the low half
  end

  always_comb
  begin
    half_d     = half_q;
    w_valid_d  = w_valid_q;
    aw_valid_d = aw_valid_q;
    offset_d   = offset_q;
    id_d       = id_q;

    if (take)
      half_d = ~half_q;

    if (aw_valid_q && aw_ready)
      aw_valid_d = 1'b0;

    if (beat_done)
    begin
      w_valid_d = 1'b0;
      offset_d  = offset_q + 1'b1;                    // Wraps inside the ring
      if (last_beat)
        id_d = id_q + 1'b1;
    end

    if (pair_done)
    begin
      w_valid_d = 1'b1;
      if (offset_d[beat_cnt_width-1:0] == '0)
        aw_valid_d = 1'b1;                            // Request goes out with the first beat
    end
  end

  assign aw       = '{id: id_q, addr: region_base + ram_addr_width'(offset_q)};
  assign aw_valid = aw_valid_q;
  assign w        = '{data: beat_q, last: last_beat};
  assign w_valid  = w_valid_q;

endmodule

/* hw/burst_arbiter.sv */
`timescale 1ns/1ps

module burst_arbiter (
  input  logic                                aclk,
  input  logic                                aresetn,
  input  capture_pkg::aw_req_t                req_aw [capture_pkg::num_writers],
  input  logic [capture_pkg::num_writers-1:0] req_aw_valid,
  output logic [capture_pkg::num_writers-1:0] req_aw_ready,
  input  capture_pkg::w_beat_t                req_w [capture_pkg::num_writers],
  input  logic [capture_pkg::num_writers-1:0] req_w_valid,
  output logic [capture_pkg::num_writers-1:0] req_w_ready,
  output capture_pkg::aw_req_t                aw,
  output logic                                aw_valid,
  input  logic                                aw_ready,
  output capture_pkg::w_beat_t                w,
  output logic                                w_valid,
  input  logic                                w_ready
);

  import capture_pkg::*;

  logic [writer_sel_width-1:0] grant_q;
  logic [writer_sel_width-1:0] last_served_q;
  logic [writer_sel_width-1:0] pick;                  // Candidate while unlocked
  logic [writer_sel_width-1:0] next_writer;
  logic                        locked_q;              // Burst in flight
  logic                        burst_end;

  assign burst_end   = w_valid & w_ready & w.last;
  assign next_writer = (grant_q == writer_sel_width'(num_writers - 1)) ? '0 : grant_q + 1'b1;

  // Keep a pending requester, otherwise search from the one after last served
  always_comb
  begin
    int   cand;
    logic found;
    cand  = 0;
    found = req_aw_valid[grant_q];
    pick  = grant_q;
    for (int i = 1; i <= num_writers; i++)
    begin
      cand = (int'(last_served_q) + i) % num_writers;
      if (!found && req_aw_valid[cand])
      begin
        pick  = writer_sel_width'(cand);
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      grant_q       <= '0;
      last_served_q <= writer_sel_width'(num_writers - 1);
      locked_q      <= 1'b0;
    end
    else if (burst_end)
    begin
      locked_q      <= 1'b0;
      last_served_q <= grant_q;
      grant_q       <= next_writer;                   // Hand over to the peer
    end
    else if (aw_valid && aw_ready)
      locked_q <= 1'b1;
    else if (!locked_q)
      grant_q <= pick;
  end

  // Zero latency routing of the granted writer
  assign aw       = req_aw[grant_q];
  assign aw_valid = req_aw_valid[grant_q];
  assign w        = req_w[grant_q];
  assign w_valid  = req_w_valid[grant_q];

  always_comb
  begin
    req_aw_ready          = '0;
    req_w_ready           = '0;
    req_aw_ready[grant_q] = aw_ready;
    req_w_ready[grant_q]  = w_ready;
  end

endmodule

/* hw/burst_ram.sv */
`timescale 1ns/1ps

module burst_ram (
  input  logic                                   aclk,
  input  logic                                   aresetn,
  input  capture_pkg::aw_req_t                   aw,
  input  logic                                   aw_valid,
  output logic                                   aw_ready,
  input  capture_pkg::w_beat_t                   w,
  input  logic                                   w_valid,
  output logic                                   w_ready,
  input  logic [capture_pkg::ram_addr_width-1:0] rd_addr,
  output logic [capture_pkg::data_width-1:0]     rd_data
);

  import capture_pkg::*;

  logic [data_width-1:0]     mem [2**ram_addr_width];
  logic                      open_q;                  // Address taken, beats pending
  logic [ram_addr_width-1:0] base_q;
  logic [beat_cnt_width-1:0] beat_cnt_q;
  logic [ram_addr_width-1:0] wr_addr;
  logic                      aw_take;
  logic                      w_take;

  assign aw_ready = ~open_q;
  assign w_ready  = open_q;
  assign aw_take  = aw_valid & aw_ready;
  assign w_take   = w_valid & w_ready;
  assign wr_addr  = base_q + ram_addr_width'(beat_cnt_q);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      open_q     <= 1'b0;
      beat_cnt_q <= '0;
    end
    else if (aw_take)
    begin
      open_q     <= 1'b1;
      beat_cnt_q <= '0;
    end
    else if (w_take)
    begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
      if (w.last)
        open_q <= 1'b0;                               // Burst closes on last
    end
  end

  always_ff @(posedge aclk)
  begin
    if (aw_take)
      base_q <= aw.addr;
  end

  always_ff @(posedge aclk)
  begin
    if (w_take)
      mem[wr_addr] <= w.data;
    rd_data <= mem[rd_addr];                          // One cycle readback
  end

endmodule

/* hw/capture_top.sv */
`timescale 1ns/1ps

module capture_top (
  input  logic                                   aclk,
  input  logic                                   aresetn,
  input  logic [capture_pkg::sample_width-1:0]   s0_tdata,
  input  logic                                   s0_tvalid,
  output logic                                   s0_tready,
  input  logic [capture_pkg::sample_width-1:0]   s1_tdata,
  input  logic                                   s1_tvalid,
  output logic                                   s1_tready,
  input  logic [capture_pkg::ram_addr_width-1:0] rd_addr,
  output logic [capture_pkg::data_width-1:0]     rd_data
);

  import capture_pkg::*;

  aw_req_t                wr_aw [num_writers];        // Per writer requests
  logic [num_writers-1:0] wr_aw_valid;
  logic [num_writers-1:0] wr_aw_ready;
  w_beat_t                wr_w [num_writers];
  logic [num_writers-1:0] wr_w_valid;
  logic [num_writers-1:0] wr_w_ready;
  aw_req_t                ram_aw;                     // Arbitrated channels
  logic                   ram_aw_valid;
  logic                   ram_aw_ready;
  w_beat_t                ram_w;
  logic                   ram_w_valid;
  logic                   ram_w_ready;

  axis_ram_writer #(
    .region_base (ram_addr_width'(0))
  ) u_writer0 (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .tdata    (s0_tdata),
    .tvalid   (s0_tvalid),
    .tready   (s0_tready),
    .aw       (wr_aw[0]),
    .aw_valid (wr_aw_valid[0]),
    .aw_ready (wr_aw_ready[0]),
    .w        (wr_w[0]),
    .w_valid  (wr_w_valid[0]),
    .w_ready  (wr_w_ready[0])
  );

  axis_ram_writer #(
    .region_base (ram_addr_width'(ring_words))        // Second ring right after the first
  ) u_writer1 (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .tdata    (s1_tdata),
    .tvalid   (s1_tvalid),
    .tready   (s1_tready),
    .aw       (wr_aw[1]),
    .aw_valid (wr_aw_valid[1]),
    .aw_ready (wr_aw_ready[1]),
    .w        (wr_w[1]),
    .w_valid  (wr_w_valid[1]),
    .w_ready  (wr_w_ready[1])
  );

  burst_arbiter u_burst_arbiter (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .req_aw       (wr_aw),
    .req_aw_valid (wr_aw_valid),
    .req_aw_ready (wr_aw_ready),
    .req_w        (wr_w),
    .req_w_valid  (wr_w_valid),
    .req_w_ready  (wr_w_ready),
    .aw           (ram_aw),
    .aw_valid     (ram_aw_valid),
    .aw_ready     (ram_aw_ready),
    .w            (ram_w),
    .w_valid      (ram_w_valid),
    .w_ready      (ram_w_ready)
  );

  burst_ram u_burst_ram (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .aw       (ram_aw),
    .aw_valid (ram_aw_valid),
    .aw_ready (ram_aw_ready),
    .w        (ram_w),
    .w_valid  (ram_w_valid),
    .w_ready  (ram_w_ready),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic aclk,
  output logic aresetn
);

  localparam int period       = 8;                    // ns
  localparam int reset_cycles = 4;

  initial
  begin
    aclk = 1'b0;
    forever #(period / 2) aclk = ~aclk;
  end

  initial
  begin
    aresetn = 1'b0;
    repeat (reset_cycles) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;                                   // Released away from the rising edge
  end

endmodule

/* tb/capture_top_properties.sv */
`timescale 1ns/1ps

module capture_top_properties (
  input logic                                     aclk,
  input logic                                     aresetn,
  input logic                                     aw_valid,
  input logic                                     aw_ready,
  input capture_pkg::w_beat_t                     w,
  input logic                                     w_valid,
  input logic                                     w_ready,
  input logic [capture_pkg::writer_sel_width-1:0] grant
);

  import capture_pkg::*;

  logic [beat_cnt_width-1:0] beats_q;                 // Accepted beats modulo the burst length
  logic                      in_burst_q;              // Address accepted and last beat pending
  logic                      beat_take;
  logic                      aw_take;
  logic                      burst_end;

  assign beat_take = w_valid & w_ready;
  assign aw_take   = aw_valid & aw_ready;
  assign burst_end = beat_take & w.last;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      beats_q    <= '0;
      in_burst_q <= 1'b0;
    end
    else
    begin
      if (beat_take)
        beats_q <= beats_q + beat_cnt_width'(1);
      if (aw_take)
        in_burst_q <= 1'b1;
      else if (burst_end)
        in_burst_q <= 1'b0;
    end
  end

  aw_valid_held: assert property (@(posedge aclk) disable iff (!aresetn)
    (aw_valid && !aw_ready) |=> aw_valid)
    else $error("aw_valid dropped before aw_ready");

  // From the address transfer up to the beat with last
  grant_locked: assert property (@(posedge aclk) disable iff (!aresetn)
    (aw_take || (in_burst_q && !burst_end)) |=> $stable(grant))
    else $error("grant changed inside a burst");

  last_on_burst_end: assert property (@(posedge aclk) disable iff (!aresetn)
    beat_take |-> (w.last == (beats_q == beat_cnt_width'(burst_len - 1))))
    else $error("last does not fall on every 16th accepted beat");

endmodule

/* tb/capture_top_tb.sv */
`timescale 1ns/1ps

module capture_top_tb;

  import capture_pkg::*;

  localparam string input_file  = "tb/capture_input.txt";
  localparam int    wait_limit  = 5000;               // Cycles before any wait gives up
  localparam int    idle_needed = 40;

  logic                      aclk;
  logic                      aresetn;
  logic [sample_width-1:0]   tdata [2];
  logic [1:0]                tvalid;
  logic [1:0]                tready;
  logic [ram_addr_width-1:0] rd_addr;
  logic [data_width-1:0]     rd_data;
  logic [15:0]               lfsr_q;
  int                        checks;
  bit                        timed_out;

  tb_clock_gen u_tb_clock_gen (.aclk(aclk), .aresetn(aresetn));

  capture_top u_capture_top (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .s0_tdata  (tdata[0]),
    .s0_tvalid (tvalid[0]),
    .s0_tready (tready[0]),
    .s1_tdata  (tdata[1]),
    .s1_tvalid (tvalid[1]),
    .s1_tready (tready[1]),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  bind burst_arbiter capture_top_properties u_capture_top_properties (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .grant    (grant_q)
  );

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  function automatic logic [data_width-1:0] sample_pair(input logic [sample_width-1:0] low);
    return {low + sample_width'(1), low};             // Later sample in the high half
  endfunction

  task automatic send_samples(input logic [1:0] mask, input bit gaps,
                              input logic [sample_width-1:0] first0,
                              input logic [sample_width-1:0] first1, input int count);
    int                      sent [2];
    int                      cycles;
    bit                      gap;
    logic [1:0]              take;
    logic [sample_width-1:0] base [2];
    base[0] = first0;
    base[1] = first1;
    cycles  = 0;
    for (int s = 0; s < 2; s++)
      sent[s] = mask[s] ? 0 : count;
    while (sent[0] < count || sent[1] < count)
    begin
      if (cycles == wait_limit)
      begin
        $display("Timeout: streams stalled after %0d and %0d of %0d samples",
                 sent[0], sent[1], count);
        timed_out = 1'b1;
        tvalid    = '0;
        return;
      end
      gap = 1'b0;
      if (gaps)
      begin
        lfsr_q = lfsr_next(lfsr_q);
        gap    = ~lfsr_q[0];
      end
      for (int s = 0; s < 2; s++)
      begin
        if (!tvalid[s])                               // A pending sample stays valid
          tvalid[s] = (sent[s] < count) && !gap;
        tdata[s] = base[s] + sample_width'(sent[s]);
        take[s]  = tvalid[s] & tready[s];             // Both hold until the next rising edge
      end
      @(negedge aclk);
      cycles++;
      for (int s = 0; s < 2; s++)
      begin
        if (take[s])
        begin
          sent[s]++;
          tvalid[s] = 1'b0;
        end
      end
    end
  endtask

  task automatic wait_drain();
    int idle;
    int cycles;
    idle   = 0;
    cycles = 0;
    while (idle < idle_needed)
    begin
      if (cycles == wait_limit)
      begin
        $display("Timeout: tready did not stay high once the samples were sent");
        timed_out = 1'b1;
        return;
      end
      @(negedge aclk);
      cycles++;
      idle = (&tready && tvalid == '0) ? idle + 1 : 0;
    end
  endtask

  // Ring offsets wrap inside the writer's region
  task automatic check_words(input int region, input int offset, input int words,
                             input logic [sample_width-1:0] first, inout int fails);
    logic [ram_addr_width-1:0] addr;
    logic [data_width-1:0]     expected;
    for (int k = 0; k < words; k++)
    begin
      addr     = ram_addr_width'(region * ring_words + (offset + k) % ring_words);
      expected = sample_pair(first + sample_width'(2 * k));
      rd_addr  = addr;
      @(negedge aclk);
      checks++;
      if (rd_data !== expected)
      begin
        $display("FAILED rd_data word %h: expected %h, actual %h", addr, expected, rd_data);
        fails++;
      end
    end
  endtask

  initial
  begin
    int          fd;
    int          fields;
    int          test_num;
    int          tests_failed;
    int          fails;
    int          errors;
    int          cycles;
    string       line;
    logic [31:0] f [13];                              // mask gaps first0 first1 count and two checks
    tdata[0]     = '0;
    tdata[1]     = '0;
    tvalid       = '0;
    rd_addr      = '0;
    lfsr_q       = 16'd30;
    checks       = 0;
    errors       = 0;
    timed_out    = 1'b0;
    test_num     = 0;
    tests_failed = 0;
    cycles       = 0;
    fd = $fopen(input_file, "r");
    if (fd == 0)
    begin
      $display("Could not open the test file %s", input_file);
      errors++;
    end
    while (fd != 0 && aresetn !== 1'b1 && !timed_out)
    begin
      if (cycles == wait_limit)
      begin
        $display("Timeout: reset was never released");
        timed_out = 1'b1;
        errors++;
      end
      @(negedge aclk);
      cycles++;
    end
    while (fd != 0 && !timed_out && $fgets(line, fd) != 0)
    begin
      if (line.len() < 2 || line.substr(0, 1) == "//")
        continue;
      fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                       f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
      test_num++;
      fails = 0;
      if (fields != 13)
      begin
        $display("Test %0d: line has %0d fields instead of 13", test_num, fields);
        fails = 1;
      end
      else
      begin
        send_samples(f[0][1:0], f[1][0], f[2], f[3], f[4]);
        if (!timed_out)
          wait_drain();
        if (!timed_out)
        begin
          check_words(f[5], f[6], f[7], f[8], fails);
          check_words(f[9], f[10], f[11], f[12], fails);
        end
        else
          fails++;
      end
      if (fails == 0)
        $display("Test %0d: ok", test_num);
      else
      begin
        $display("Test %0d: %0d errors", test_num, fails);
        tests_failed++;
      end
      errors += fails;
    end
    if (fd != 0)
      $fclose(fd);
    $display("Tests: %0d, failed: %0d, words checked: %0d, errors: %0d",
             test_num, tests_failed, checks, errors);
    if (errors == 0 && test_num > 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

/* tb/capture_input.txt */
// mask(1=s0 2=s1 3=both) gaps first0 first1 count, then two checks of
// region offset words first_low_sample (all hex, words 0 skips a check)
1 0 00000000 00000000 020  0 00 10 00000000  0 00 00 00000000
2 1 00000000 10000000 040  1 00 20 10000000  0 00 10 00000000
3 1 20000000 30000000 060  0 10 30 20000000  1 20 30 30000000
1 1 40000000 00000000 0a0  0 10 40 40000020  1 20 20 30000000
2 1 00000000 50000000 007  1 10 03 50000000  1 13 0d 10000026

/* filelist.f */
hw/capture_pkg.sv
hw/axis_ram_writer.sv
hw/burst_arbiter.sv
hw/burst_ram.sv
hw/capture_top.sv
tb/tb_clock_gen.sv
tb/capture_top_properties.sv
tb/capture_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= capture_top_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps
PASS_TEXT ?= All tests passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
